// ==== rtl/ws2812_defines.svh ====
`ifndef WS2812_DEFINES_SVH
`define WS2812_DEFINES_SVH

// ------------------------------------------------------------
// Counter and configuration widths
// ------------------------------------------------------------

// Pulse and idle counters, and the threshold/idle config values
`define WS_CNT_W 32

// ------------------------------------------------------------
// Reset defaults
// ------------------------------------------------------------

`define WS_THRESHOLD_DEFAULT 38     // High time above this decodes as a 1
`define WS_IDLE_DEFAULT 3840        // Low cycles before the line counts as idle
`define WS_DIN_SEL_DEFAULT 1        // ui_in bit watched after reset

// Bits kept per frame, G then R then B
`define WS_FRAME_BITS 24

`endif

// ==== rtl/ws2812_bus_pkg.sv ====
package ws2812_bus_pkg;

    // Register map of the peripheral, one byte per address
    typedef enum logic [3:0] {
        ADDR_RED     = 4'd0,    // Read only
        ADDR_GREEN   = 4'd1,
        ADDR_BLUE    = 4'd2,
        ADDR_CLEAR   = 4'd3,    // Write clears ready
        ADDR_STATUS  = 4'd4,    // FF when a frame is held
        ADDR_COMMIT  = 4'd5,    // Write copies shadow config to active
        ADDR_IDLE_B0 = 4'd6,    // Idle time, LSB first
        ADDR_IDLE_B1 = 4'd7,
        ADDR_IDLE_B2 = 4'd8,
        ADDR_IDLE_B3 = 4'd9,
        ADDR_THR_B0  = 4'd10,   // Bit threshold, LSB first
        ADDR_THR_B1  = 4'd11,
        ADDR_THR_B2  = 4'd12,
        ADDR_THR_B3  = 4'd13,
        ADDR_DIN_SEL = 4'd14    // Input pin select, bits 2:0
    } reg_addr_e;

endpackage

// ==== rtl/ws2812_line_pkg.sv ====
package ws2812_line_pkg;

    // Decoder view of the line level
    typedef enum logic {
        LINE_LOW  = 1'b0,
        LINE_HIGH = 1'b1
    } dec_state_e;

    // Forwarder mode
    typedef enum logic {
        FWD_BLOCK = 1'b0,   // Own bits, keep output low
        FWD_PASS  = 1'b1    // Pass raw line to next LED
    } fwd_state_e;

endpackage

// ==== rtl/ws2812_line_decoder.sv ====
`timescale 1ns/10ps
`include "ws2812_defines.svh"

module ws2812_line_decoder
    import ws2812_line_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 din,               // Selected input pin
    input  logic [`WS_CNT_W-1:0] threshold_cycles,  // High time limit for a 0
    input  logic [`WS_CNT_W-1:0] idle_ticks,        // Low time that means idle
    output logic                 bit_valid,         // One-cycle strobe per bit
    output logic                 bit_value,
    output logic                 idle               // Level, line reset seen
);

    dec_state_e           state;        // Registered copy of the line level
    logic [`WS_CNT_W-1:0] high_cnt;     // Cycles sampled high in this pulse
    logic [`WS_CNT_W-1:0] idle_cnt;     // Cycles sampled low
    logic [`WS_CNT_W-1:0] idle_cnt_nxt;

    // ------------------------------------------------------------
    // High pulse measurement
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= LINE_LOW;
            bit_valid <= 1'b0;
        end else begin
            bit_valid <= 1'b0;              // Strobe by default
            case (state)
                LINE_LOW: begin
                    if (din) begin
                        state    <= LINE_HIGH;
                        high_cnt <= `WS_CNT_W'(1);  // First high sample
                    end
                end
                LINE_HIGH: begin
                    if (din) begin
                        if (high_cnt != '1)         // Saturate on a stuck line
                            high_cnt <= high_cnt + 1'b1;
                    end else begin
                        // Falling edge, judge the pulse
                        state     <= LINE_LOW;
                        bit_valid <= 1'b1;
                        bit_value <= (high_cnt > threshold_cycles);
                    end
                end
                default: state <= LINE_LOW;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Idle detection
    // ------------------------------------------------------------
    assign idle_cnt_nxt = (idle_cnt == '1) ? idle_cnt : idle_cnt + 1'b1;

    always_ff @(posedge clk) begin
        if (reset) begin
            idle_cnt <= '0;
            idle     <= 1'b0;
        end else if (din) begin
            idle_cnt <= '0;                 // Any high sample ends idle
            idle     <= 1'b0;
        end else begin
            idle_cnt <= idle_cnt_nxt;
            idle     <= (idle_cnt_nxt >= idle_ticks);
        end
    end

    // A bit needs a new high pulse, so strobes never run back to back
    assert property (@(posedge clk) disable iff (reset) bit_valid |=> !bit_valid)
        else $error("bit_valid high in two consecutive cycles");

endmodule

// ==== rtl/ws2812_frame_capture.sv ====
`timescale 1ns/10ps
`include "ws2812_defines.svh"

module ws2812_frame_capture (
    input  logic       clk,
    input  logic       reset,
    input  logic       bit_valid,
    input  logic       bit_value,
    input  logic       idle,
    output logic [7:0] red,
    output logic [7:0] green,
    output logic [7:0] blue,
    output logic       frame_done      // With the bit_valid of the last bit
);

    localparam int FRAME_BYTES = `WS_FRAME_BITS / 8;

    logic [7:0] shift_q;               // Byte in progress, MSB first
    logic [2:0] bit_cnt;               // Bits in shift_q
    logic [1:0] byte_idx;              // 0 G, 1 R, 2 B, 3 frame full
    logic [7:0] byte_next;
    logic       take_bit;
    logic       byte_done;

    assign byte_next  = {shift_q[6:0], bit_value};
    assign take_bit   = bit_valid && !idle && (byte_idx != 2'(FRAME_BYTES));
    assign byte_done  = take_bit && (bit_cnt == 3'd7);
    assign frame_done = byte_done && (byte_idx == 2'(FRAME_BYTES - 1));

    // ------------------------------------------------------------
    // Bit to byte assembly
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset || idle) begin
            bit_cnt  <= 3'd0;           // Line reset starts a new frame
            byte_idx <= 2'd0;
        end else if (take_bit) begin
            bit_cnt <= bit_cnt + 1'b1;  // Wraps after 8
            if (byte_done)
                byte_idx <= byte_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take_bit)
            shift_q <= byte_next;
    end

    // ------------------------------------------------------------
    // Colour capture, WS2812 order G R B
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            red   <= 8'h00;
            green <= 8'h00;
            blue  <= 8'h00;
        end else if (byte_done) begin
            case (byte_idx)
                2'd0:    green <= byte_next;
                2'd1:    red   <= byte_next;
                2'd2:    blue  <= byte_next;
                default: ;                  // Frame already full
            endcase
        end
    end

    // Frame completion is tied to the strobe of the final bit
    assert property (@(posedge clk) disable iff (reset) frame_done |-> bit_valid)
        else $error("frame_done without bit_valid");

endmodule

// ==== rtl/ws2812_forwarder.sv ====
`timescale 1ns/10ps

module ws2812_forwarder
    import ws2812_line_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic din,          // Raw selected pin
    input  logic frame_done,   // Own 24 bits taken
    input  logic idle,
    output logic dout          // Line to the next device
);

    fwd_state_e state;
    fwd_state_e state_nxt;

    // ------------------------------------------------------------
    // Mode control
    // ------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            FWD_BLOCK: if (frame_done) state_nxt = FWD_PASS;
            FWD_PASS:  if (idle)       state_nxt = FWD_BLOCK;   // End of the chain frame
            default:   state_nxt = FWD_BLOCK;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FWD_BLOCK;
            dout  <= 1'b0;
        end else begin
            state <= state_nxt;
            // Registered raw line, forced low while blocking
            dout  <= (state_nxt == FWD_PASS) ? din : 1'b0;
        end
    end

    // Nothing may leak downstream while the receiver owns the line
    assert property (@(posedge clk) disable iff (reset) (state == FWD_BLOCK) |-> !dout)
        else $error("dout high in FWD_BLOCK");

endmodule

// ==== rtl/ws2812_regs.sv ====
`timescale 1ns/10ps
`include "ws2812_defines.svh"

module ws2812_regs
    import ws2812_bus_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic [3:0]           address,
    input  logic                 data_write,
    input  logic [7:0]           data_in,
    output logic [7:0]           data_out,
    input  logic [7:0]           red,
    input  logic [7:0]           green,
    input  logic [7:0]           blue,
    input  logic                 frame_done,
    input  logic                 idle,
    output logic [`WS_CNT_W-1:0] threshold_cycles,  // Active values
    output logic [`WS_CNT_W-1:0] idle_ticks,
    output logic [2:0]           din_sel
);

    reg_addr_e            addr;
    logic [`WS_CNT_W-1:0] shadow_threshold;     // Written byte by byte
    logic [`WS_CNT_W-1:0] shadow_idle;
    logic                 commit_pend;          // Commit seen last cycle
    logic                 ready;                // Frame held, not yet cleared
    logic                 clear_wr;

    assign addr     = reg_addr_e'(address);
    assign clear_wr = data_write && (addr == ADDR_CLEAR);

    // ------------------------------------------------------------
    // Shadow config and delayed commit
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            shadow_threshold <= `WS_CNT_W'(`WS_THRESHOLD_DEFAULT);
            shadow_idle      <= `WS_CNT_W'(`WS_IDLE_DEFAULT);
            threshold_cycles <= `WS_CNT_W'(`WS_THRESHOLD_DEFAULT);
            idle_ticks       <= `WS_CNT_W'(`WS_IDLE_DEFAULT);
            commit_pend      <= 1'b0;
        end else begin
            commit_pend <= data_write && (addr == ADDR_COMMIT);
            if (commit_pend) begin
                threshold_cycles <= shadow_threshold;   // Both apply together
                idle_ticks       <= shadow_idle;
            end
            if (data_write) begin
                case (addr)
                    ADDR_IDLE_B0: shadow_idle[7:0]        <= data_in;
                    ADDR_IDLE_B1: shadow_idle[15:8]       <= data_in;
                    ADDR_IDLE_B2: shadow_idle[23:16]      <= data_in;
                    ADDR_IDLE_B3: shadow_idle[31:24]      <= data_in;
                    ADDR_THR_B0:  shadow_threshold[7:0]   <= data_in;
                    ADDR_THR_B1:  shadow_threshold[15:8]  <= data_in;
                    ADDR_THR_B2:  shadow_threshold[23:16] <= data_in;
                    ADDR_THR_B3:  shadow_threshold[31:24] <= data_in;
                    default: ;
                endcase
            end
        end
    end

    // Pin select, takes effect at the next edge
    always_ff @(posedge clk) begin
        if (reset)
            din_sel <= 3'(`WS_DIN_SEL_DEFAULT);
        else if (data_write && (addr == ADDR_DIN_SEL))
            din_sel <= data_in[2:0];
    end

    // ------------------------------------------------------------
    // Ready flag, clear wins over a new frame
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset || idle)
            ready <= 1'b0;
        else if (clear_wr)
            ready <= 1'b0;
        else if (frame_done)
            ready <= 1'b1;
    end

    // Read mux
    always_comb begin
        case (addr)
            ADDR_RED:    data_out = red;
            ADDR_GREEN:  data_out = green;
            ADDR_BLUE:   data_out = blue;
            ADDR_STATUS: data_out = ready ? 8'hFF : 8'h00;
            default:     data_out = 8'h00;
        endcase
    end

    // Decoder settings move only on the edge after a commit write
    assert property (@(posedge clk) disable iff (reset)
        ($changed(threshold_cycles) || $changed(idle_ticks)) |-> $past(commit_pend))
        else $error("active config changed without a pending commit");

endmodule

// ==== rtl/ws2812_peripheral.sv ====
`timescale 1ns/10ps
`include "ws2812_defines.svh"

module ws2812_peripheral (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] ui_in,       // Input port, already synchronised
    output logic [7:0] uo_out,
    input  logic [3:0] address,
    input  logic       data_write,
    input  logic [7:0] data_in,
    output logic [7:0] data_out
);

    logic                 din;
    logic                 dout;
    logic                 bit_valid;
    logic                 bit_value;
    logic                 idle;
    logic                 frame_done;
    logic [7:0]           red;
    logic [7:0]           green;
    logic [7:0]           blue;
    logic [`WS_CNT_W-1:0] threshold_cycles;
    logic [`WS_CNT_W-1:0] idle_ticks;
    logic [2:0]           din_sel;

    // ------------------------------------------------------------
    // Pin select and output fan out
    // ------------------------------------------------------------
    assign din    = ui_in[din_sel];
    assign uo_out = {8{dout}};      // Any pin can carry the chain output

    ws2812_line_decoder u_decoder (
        .clk(clk), .reset(reset), .din(din),
        .threshold_cycles(threshold_cycles), .idle_ticks(idle_ticks),
        .bit_valid(bit_valid), .bit_value(bit_value), .idle(idle)
    );

    ws2812_frame_capture u_capture (
        .clk(clk), .reset(reset),
        .bit_valid(bit_valid), .bit_value(bit_value), .idle(idle),
        .red(red), .green(green), .blue(blue), .frame_done(frame_done)
    );

    ws2812_forwarder u_forwarder (
        .clk(clk), .reset(reset), .din(din),
        .frame_done(frame_done), .idle(idle), .dout(dout)
    );

    ws2812_regs u_regs (
        .clk(clk), .reset(reset),
        .address(address), .data_write(data_write),
        .data_in(data_in), .data_out(data_out),
        .red(red), .green(green), .blue(blue),
        .frame_done(frame_done), .idle(idle),
        .threshold_cycles(threshold_cycles), .idle_ticks(idle_ticks),
        .din_sel(din_sel)
    );

endmodule

// ==== tests/ws2812_tb.sv ====
`timescale 1ns/10ps
`include "ws2812_defines.svh"

module ws2812_tb
    import ws2812_bus_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 60000;  // About 26k cycles of stimulus plus margin

    logic        clk;
    logic        reset;
    logic [7:0]  ui_in;
    logic [7:0]  uo_out;
    logic [3:0]  address;
    logic        data_write;
    logic [7:0]  data_in;
    logic [7:0]  data_out;

    logic        line_level;        // Level on the driven pin
    logic        line_prev;         // line_level one edge back
    int          line_pin;
    int          t_high0;           // High cycles of a 0 bit
    int          t_high1;           // High cycles of a 1 bit
    int          t_period;
    logic [31:0] lfsr_state;
    int          cycle_cnt = 0;
    logic        expect_block;      // uo_out must stay 00
    logic        expect_pass;       // uo_out must follow the line

    // Reference model of the register map
    logic [7:0]  exp_red;
    logic [7:0]  exp_green;
    logic [7:0]  exp_blue;
    logic        exp_ready;
    logic [31:0] exp_threshold;     // Active values
    logic [31:0] exp_idle_ticks;
    logic [31:0] shadow_threshold;
    logic [31:0] shadow_idle;
    logic [2:0]  exp_din_sel;

    assign ui_in = line_level ? (8'h01 << line_pin) : 8'h00;   // Only the driven pin moves

    ws2812_peripheral dut0 (
        .clk(clk), .reset(reset), .ui_in(ui_in), .uo_out(uo_out),
        .address(address), .data_write(data_write),
        .data_in(data_in), .data_out(data_out)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;              // 40 ns period

    always @(posedge clk) begin
        line_prev <= line_level;
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            abort_run($sformatf("Timeout: run exceeded %0d clock cycles", TIMEOUT_CYCLES));
    end

    // ------------------------------------------------------------
    // Failure reporting
    // ------------------------------------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic fail_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        abort_run($sformatf("[ERROR] %s: got %h, expected %h", name, got, exp));
    endtask

    // Own bits stay blocked and the raw line then follows one cycle late
    assert property (@(posedge clk) disable iff (reset) expect_block |-> (uo_out == 8'h00))
        else fail_value("uo_out", uo_out, 8'h00);
    assert property (@(posedge clk) disable iff (reset)
        expect_pass |-> (uo_out == {8{line_prev}}))
        else fail_value("uo_out", uo_out, {8{line_prev}});

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // x^32+x^22+x^2+x+1
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);     // One step per bit
            bits       = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // Bits as the receiver should read them with the active threshold
    function automatic logic [23:0] decode_frame(input logic [23:0] data);
        logic [23:0] decoded;
        int          high_cycles;
        for (int i = 0; i < 24; i++) begin
            high_cycles = data[i] ? t_high1 : t_high0;
            decoded[i]  = (high_cycles > exp_threshold);
        end
        return decoded;
    endfunction

    task automatic check_read(input logic [3:0] addr, input logic [7:0] exp);
        @(negedge clk);
        address = addr;
        @(negedge clk);
        assert (data_out == exp)
            else fail_value($sformatf("data_out at address %0d", addr), data_out, exp);
    endtask

    task automatic check_regs();
        check_read(ADDR_RED, exp_red);
        check_read(ADDR_GREEN, exp_green);
        check_read(ADDR_BLUE, exp_blue);
        check_read(ADDR_STATUS, exp_ready ? 8'hFF : 8'h00);
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [7:0] value);
        @(negedge clk);
        address    = addr;
        data_in    = value;
        data_write = 1'b1;
        @(negedge clk);
        data_write = 1'b0;
        if (addr == ADDR_CLEAR)
            exp_ready = 1'b0;
        else if (addr == ADDR_COMMIT) begin
            exp_threshold  = shadow_threshold;  // Settles two edges later
            exp_idle_ticks = shadow_idle;
        end else if (addr >= ADDR_IDLE_B0 && addr <= ADDR_IDLE_B3)
            shadow_idle[8*(addr - ADDR_IDLE_B0) +: 8] = value;
        else if (addr >= ADDR_THR_B0 && addr <= ADDR_THR_B3)
            shadow_threshold[8*(addr - ADDR_THR_B0) +: 8] = value;
        else if (addr == ADDR_DIN_SEL)
            exp_din_sel = value[2:0];
    endtask

    task automatic write_config_word(input logic [3:0] base, input logic [31:0] value);
        for (int i = 0; i < 4; i++)
            write_reg(base + 4'(i), value[8*i +: 8]);   // LSB first
    endtask

    task automatic drive_bit(input logic value);
        int high_cycles;
        high_cycles = value ? t_high1 : t_high0;
        @(negedge clk);
        line_level = 1'b1;
        repeat (high_cycles) @(negedge clk);
        line_level = 1'b0;
        repeat (t_period - high_cycles - 1) @(negedge clk);
    endtask

    task automatic send_frame(input int pin, input logic [23:0] data, input int n_extra);
        logic [23:0] decoded;
        logic [31:0] extra;
        @(negedge clk);
        line_pin     = pin;
        expect_block = 1'b1;
        for (int i = 23; i >= 0; i--)
            drive_bit(data[i]);                 // Sent MSB first in G R B order
        expect_block = 1'b0;
        if (pin == exp_din_sel) begin
            decoded     = decode_frame(data);
            exp_green   = decoded[23:16];
            exp_red     = decoded[15:8];
            exp_blue    = decoded[7:0];
            exp_ready   = 1'b1;
            expect_pass = (n_extra > 0);        // Chain data for the next LED
        end
        extra = random_bits(n_extra);
        for (int i = n_extra - 1; i >= 0; i--)
            drive_bit(extra[i]);
        expect_pass = 1'b0;
    endtask

    task automatic idle_gap(input int cycles);
        repeat (cycles) @(negedge clk);
        if (cycles > exp_idle_ticks)
            exp_ready = 1'b0;                   // Line reset drops ready
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        logic [23:0] frame;
        reset        = 1'b1;
        address      = 4'h0;
        data_write   = 1'b0;
        data_in      = 8'h00;
        line_level   = 1'b0;
        line_prev    = 1'b0;
        line_pin     = `WS_DIN_SEL_DEFAULT;
        expect_block = 1'b0;
        expect_pass  = 1'b0;
        lfsr_state   = 32'he07d_8eee;
        exp_red      = 8'h00;
        exp_green    = 8'h00;
        exp_blue     = 8'h00;
        exp_ready    = 1'b0;
        exp_threshold    = `WS_THRESHOLD_DEFAULT;
        exp_idle_ticks   = `WS_IDLE_DEFAULT;
        shadow_threshold = `WS_THRESHOLD_DEFAULT;
        shadow_idle      = `WS_IDLE_DEFAULT;
        exp_din_sel      = `WS_DIN_SEL_DEFAULT;
        t_high0  = 20;                          // Standard line timing
        t_high1  = 50;
        t_period = 75;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int a = 0; a < 16; a++)
            check_read(4'(a), 8'h00);           // Whole map reads 00 after reset
        assert (uo_out == 8'h00) else fail_value("uo_out", uo_out, 8'h00);

        // Capture plus forwarding of 8 extra bits
        send_frame(1, 24'(random_bits(24)), 8);
        check_regs();
        idle_gap(4000);
        check_regs();                           // Idle alone clears status

        // Output blocked again after idle, then clear and a fresh frame
        send_frame(1, 24'(random_bits(24)), 0);
        check_regs();
        write_reg(ADDR_CLEAR, 8'h00);
        check_regs();
        idle_gap(4000);
        send_frame(1, 24'(random_bits(24)), 0);
        check_regs();
        idle_gap(4000);

        // Short timing with the shadow written but not committed
        write_config_word(ADDR_THR_B0, 32'd10);
        write_config_word(ADDR_IDLE_B0, 32'd500);
        t_high0  = 6;
        t_high1  = 15;
        t_period = 20;
        send_frame(1, 24'(random_bits(24)), 0); // Old threshold decodes all zeros
        check_regs();
        idle_gap(4000);
        write_reg(ADDR_COMMIT, 8'h00);
        send_frame(1, 24'(random_bits(24)), 0);
        check_regs();
        idle_gap(600);
        check_regs();

        // Pin select moves the receiver to pin 4
        write_reg(ADDR_DIN_SEL, 8'h04);
        frame = 24'(random_bits(24));
        send_frame(1, frame, 0);                // Unwatched pin
        check_regs();
        idle_gap(600);
        send_frame(4, frame, 0);
        check_regs();
        idle_gap(600);
        check_regs();

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/ws2812_bus_pkg.sv
rtl/ws2812_line_pkg.sv
rtl/ws2812_line_decoder.sv
rtl/ws2812_frame_capture.sv
rtl/ws2812_forwarder.sv
rtl/ws2812_regs.sv
rtl/ws2812_peripheral.sv
tests/ws2812_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the WS2812 receiver testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module ws2812_tb -o ws2812_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/ws2812_sim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
